// File: Bender.yml
package:
  name: ooo_core

sources:
  - rob_pkg.sv
  - rename_stage.sv
  - exec_stage.sv
  - cdb_arbiter.sv
  - reorder_buffer.sv
  - ooo_core_top.sv
  - target: simulation
    files:
      - tb_ooo_core.sv

// File: cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        alu_valid,
  input  logic [rob_pkg::TAG_W-1:0]   alu_tag,
  input  logic [rob_pkg::DATA_W-1:0]  alu_value,
  input  logic                        mul_valid,
  input  logic [rob_pkg::TAG_W-1:0]   mul_tag,
  input  logic [rob_pkg::DATA_W-1:0]  mul_value,
  input  logic                        flush_valid,
  output logic                        alu_stall,
  output logic                        cdb_valid,
  output logic [rob_pkg::TAG_W-1:0]   cdb_tag,
  output logic [rob_pkg::DATA_W-1:0]  cdb_value
);
  import rob_pkg::*;

  // one-entry skid for an alu result that lost to the multiplier
  logic              skid_valid;
  logic [TAG_W-1:0]  skid_tag;
  logic [DATA_W-1:0] skid_value;

  // alu output is not consumed while the skid holds data
  assign alu_stall = skid_valid;

  always_ff @(posedge clk_in) begin
    if (rst_in || flush_valid) begin
      cdb_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      cdb_valid <= mul_valid || skid_valid || alu_valid;
      // mul first, then skid, then fresh alu
      if (mul_valid) begin
        cdb_tag   <= mul_tag;
        cdb_value <= mul_value;
      end else if (skid_valid) begin
        cdb_tag   <= skid_tag;
        cdb_value <= skid_value;
      end else begin
        cdb_tag   <= alu_tag;
        cdb_value <= alu_value;
      end
      if (skid_valid) begin
        // drains once the multiplier is idle
        skid_valid <= mul_valid;
      end else if (mul_valid && alu_valid) begin
        skid_valid <= 1'b1;
        skid_tag   <= alu_tag;
        skid_value <= alu_value;
      end
    end
  end

  // a stalled alu result must wait unchanged, the skid cannot take it
  a_alu_held: assert property (@(posedge clk_in) disable iff (rst_in)
    (alu_stall && alu_valid && !flush_valid) |=>
      (alu_valid && $stable(alu_tag) && $stable(alu_value)));

endmodule

// File: exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        issue_valid,
  input  rob_pkg::opcode_e            issue_op,
  input  logic [rob_pkg::TAG_W-1:0]   issue_tag,
  input  logic [rob_pkg::DATA_W-1:0]  issue_a,
  input  logic [rob_pkg::DATA_W-1:0]  issue_b,
  input  logic                        alu_stall,
  input  logic                        flush_valid,
  output logic                        issue_ready,
  output logic                        alu_valid,
  output logic [rob_pkg::TAG_W-1:0]   alu_tag,
  output logic [rob_pkg::DATA_W-1:0]  alu_value,
  output logic                        mul_valid,
  output logic [rob_pkg::TAG_W-1:0]   mul_tag,
  output logic [rob_pkg::DATA_W-1:0]  mul_value
);
  import rob_pkg::*;

  logic              issue_fire;
  logic [DATA_W-1:0] alu_result;

  // multiplier pipeline state
  logic [MUL_STAGES-1:0] mul_v;
  logic [TAG_W-1:0]      mul_t [MUL_STAGES];
  logic [DATA_W-1:0]     mul_p [MUL_STAGES];

  // alu output is held while the arbiter skid is full
  assign issue_ready = !alu_stall;
  assign issue_fire  = issue_valid && issue_ready;

  always_comb begin
    case (issue_op)
      OP_LI:    alu_result = issue_a;
      OP_ADD:   alu_result = issue_a + issue_b;
      OP_SUB:   alu_result = issue_a - issue_b;
      OP_AND:   alu_result = issue_a & issue_b;
      OP_XOR:   alu_result = issue_a ^ issue_b;
      // effective address
      OP_STORE: alu_result = issue_a + issue_b;
      // taken flag in bit 0
      OP_BEQ:   alu_result = {{(DATA_W-1){1'b0}}, issue_a == issue_b};
      default:  alu_result = '0;
    endcase
  end

  // alu output register
  always_ff @(posedge clk_in) begin
    if (rst_in || flush_valid) begin
      alu_valid <= 1'b0;
    end else if (!alu_stall) begin
      alu_valid <= issue_fire && issue_op != OP_MUL;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!alu_stall) begin
      alu_tag   <= issue_tag;
      alu_value <= alu_result;
    end
  end

  // valid shift chain, one bit per stage
  always_ff @(posedge clk_in) begin
    if (rst_in || flush_valid) begin
      mul_v <= '0;
    end else begin
      mul_v <= {mul_v[MUL_STAGES-2:0], issue_fire && issue_op == OP_MUL};
    end
  end

  // product formed in stage 0, then carried with its tag
  always_ff @(posedge clk_in) begin
    mul_t[0] <= issue_tag;
    mul_p[0] <= issue_a * issue_b;
    for (int i = 1; i < MUL_STAGES; i++) begin
      mul_t[i] <= mul_t[i-1];
      mul_p[i] <= mul_p[i-1];
    end
  end

  assign mul_valid = mul_v[MUL_STAGES-1];
  assign mul_tag   = mul_t[MUL_STAGES-1];
  assign mul_value = mul_p[MUL_STAGES-1];

  // rename must not issue while the alu output is held
  a_no_issue_stalled: assert property (@(posedge clk_in) disable iff (rst_in)
    alu_stall |-> !issue_valid);

endmodule

// File: ooo_core_top.sv
`timescale 1ns/100ps

module ooo_core_top (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        instr_valid,
  input  rob_pkg::opcode_e            instr_op,
  input  logic [rob_pkg::REG_W-1:0]   instr_rd,
  input  logic [rob_pkg::REG_W-1:0]   instr_rs1,
  input  logic [rob_pkg::REG_W-1:0]   instr_rs2,
  input  logic [rob_pkg::DATA_W-1:0]  instr_imm,
  input  logic                        store_ready,
  output logic                        instr_ready,
  output logic                        commit_valid,
  output logic [rob_pkg::REG_W-1:0]   commit_rd,
  output logic [rob_pkg::DATA_W-1:0]  commit_value,
  output logic                        store_valid,
  output logic [rob_pkg::DATA_W-1:0]  store_addr,
  output logic [rob_pkg::DATA_W-1:0]  store_data,
  output logic                        flush_valid,
  output logic [rob_pkg::DATA_W-1:0]  flush_pc
);
  import rob_pkg::*;

  // rename to rob
  logic              alloc_valid;
  logic              alloc_ready;
  opcode_e           alloc_op;
  logic [REG_W-1:0]  alloc_rd;
  logic [DATA_W-1:0] alloc_data;
  logic [DATA_W-1:0] alloc_imm;
  logic [TAG_W-1:0]  alloc_tag;
  logic [TAG_W-1:0]  lookup_tag1;
  logic [TAG_W-1:0]  lookup_tag2;
  logic [DATA_W-1:0] lookup_value1;
  logic [DATA_W-1:0] lookup_value2;
  logic              lookup_ready1;
  logic              lookup_ready2;
  logic [TAG_W-1:0]  commit_tag;

  // rename to execute
  logic              issue_valid;
  logic              issue_ready;
  opcode_e           issue_op;
  logic [TAG_W-1:0]  issue_tag;
  logic [DATA_W-1:0] issue_a;
  logic [DATA_W-1:0] issue_b;

  // execute to arbiter
  logic              alu_valid;
  logic [TAG_W-1:0]  alu_tag;
  logic [DATA_W-1:0] alu_value;
  logic              mul_valid;
  logic [TAG_W-1:0]  mul_tag;
  logic [DATA_W-1:0] mul_value;
  logic              alu_stall;

  // common data bus
  logic              cdb_valid;
  logic [TAG_W-1:0]  cdb_tag;
  logic [DATA_W-1:0] cdb_value;

  rename_stage u_rename (.*);

  exec_stage u_exec (.*);

  cdb_arbiter u_arb (.*);

  reorder_buffer u_rob (.*);

endmodule

// File: rename_stage.sv
`timescale 1ns/100ps

module rename_stage (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        instr_valid,
  input  rob_pkg::opcode_e            instr_op,
  input  logic [rob_pkg::REG_W-1:0]   instr_rd,
  input  logic [rob_pkg::REG_W-1:0]   instr_rs1,
  input  logic [rob_pkg::REG_W-1:0]   instr_rs2,
  input  logic [rob_pkg::DATA_W-1:0]  instr_imm,
  input  logic                        alloc_ready,
  input  logic [rob_pkg::TAG_W-1:0]   alloc_tag,
  input  logic [rob_pkg::DATA_W-1:0]  lookup_value1,
  input  logic                        lookup_ready1,
  input  logic [rob_pkg::DATA_W-1:0]  lookup_value2,
  input  logic                        lookup_ready2,
  input  logic                        issue_ready,
  input  logic                        cdb_valid,
  input  logic [rob_pkg::TAG_W-1:0]   cdb_tag,
  input  logic [rob_pkg::DATA_W-1:0]  cdb_value,
  input  logic                        commit_valid,
  input  logic [rob_pkg::REG_W-1:0]   commit_rd,
  input  logic [rob_pkg::DATA_W-1:0]  commit_value,
  input  logic [rob_pkg::TAG_W-1:0]   commit_tag,
  input  logic                        flush_valid,
  output logic                        instr_ready,
  output logic                        alloc_valid,
  output rob_pkg::opcode_e            alloc_op,
  output logic [rob_pkg::REG_W-1:0]   alloc_rd,
  output logic [rob_pkg::DATA_W-1:0]  alloc_data,
  output logic [rob_pkg::DATA_W-1:0]  alloc_imm,
  output logic [rob_pkg::TAG_W-1:0]   lookup_tag1,
  output logic [rob_pkg::TAG_W-1:0]   lookup_tag2,
  output logic                        issue_valid,
  output rob_pkg::opcode_e            issue_op,
  output logic [rob_pkg::TAG_W-1:0]   issue_tag,
  output logic [rob_pkg::DATA_W-1:0]  issue_a,
  output logic [rob_pkg::DATA_W-1:0]  issue_b
);
  import rob_pkg::*;

  // architectural registers and alias table
  logic [DATA_W-1:0]   arf [NUM_REGS];
  logic [NUM_REGS-1:0] alias_valid;
  logic [TAG_W-1:0]    alias_tag [NUM_REGS];

  // {ready, value} per source operand
  logic [DATA_W:0] op1_res;
  logic [DATA_W:0] op2_res;
  logic            ops_ready;
  logic            writes_rd;
  logic            fire;
  // some live alias still names the free rob slot
  logic            tag_aliased;

  // operand priority: r0, register file, cdb bypass, rob lookup
  function automatic logic [DATA_W:0] resolve(input logic [REG_W-1:0] idx,
                                              input logic [DATA_W-1:0] rob_val,
                                              input logic rob_rdy);
    if (idx == '0) begin
      return {1'b1, {DATA_W{1'b0}}};
    end else if (!alias_valid[idx]) begin
      return {1'b1, arf[idx]};
    end else if (cdb_valid && cdb_tag == alias_tag[idx]) begin
      return {1'b1, cdb_value};
    end
    return {rob_rdy, rob_val};
  endfunction

  // rob answers combinationally for the aliased tags
  assign lookup_tag1 = alias_tag[instr_rs1];
  assign lookup_tag2 = alias_tag[instr_rs2];

  always_comb begin
    op1_res = resolve(instr_rs1, lookup_value1, lookup_ready1);
    op2_res = resolve(instr_rs2, lookup_value2, lookup_ready2);
    // li has no register sources
    ops_ready = (instr_op == OP_LI) || (op1_res[DATA_W] && op2_res[DATA_W]);
    writes_rd = !(instr_op inside {OP_BEQ, OP_STORE});
  end

  always_comb begin
    tag_aliased = 1'b0;
    for (int i = 1; i < NUM_REGS; i++) begin
      if (alias_valid[i] && alias_tag[i] == alloc_tag) begin
        tag_aliased = 1'b1;
      end
    end
  end

  // dispatch needs operands, a free rob slot and a free alu
  assign fire = instr_valid && ops_ready && alloc_ready && issue_ready && !flush_valid;
  assign instr_ready = fire;

  assign alloc_valid = fire;
  assign alloc_op    = instr_op;
  assign alloc_rd    = instr_rd;
  // store data is rs2
  assign alloc_data  = op2_res[DATA_W-1:0];
  assign alloc_imm   = instr_imm;

  assign issue_valid = fire;
  assign issue_op    = instr_op;
  assign issue_tag   = alloc_tag;
  assign issue_a     = (instr_op == OP_LI) ? instr_imm : op1_res[DATA_W-1:0];
  // stores compute rs1 + imm in the alu
  assign issue_b     = (instr_op == OP_STORE) ? instr_imm : op2_res[DATA_W-1:0];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        arf[i] <= '0;
      end
      alias_valid <= '0;
    end else begin
      // r0 stays zero
      if (commit_valid && commit_rd != '0) begin
        arf[commit_rd] <= commit_value;
      end
      if (flush_valid) begin
        alias_valid <= '0;
      end else begin
        // release alias only if no younger writer took it
        if (commit_valid && alias_tag[commit_rd] == commit_tag) begin
          alias_valid[commit_rd] <= 1'b0;
        end
        // new writer wins over a same-cycle release
        if (fire && writes_rd && instr_rd != '0) begin
          alias_valid[instr_rd] <= 1'b1;
          alias_tag[instr_rd]   <= alloc_tag;
        end
      end
    end
  end

  // a committed entry must have released its alias before its slot is reused
  a_free_tag_unaliased: assert property (@(posedge clk_in) disable iff (rst_in)
    fire |-> !tag_aliased);

endmodule

// File: reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        alloc_valid,
  input  rob_pkg::opcode_e            alloc_op,
  input  logic [rob_pkg::REG_W-1:0]   alloc_rd,
  input  logic [rob_pkg::DATA_W-1:0]  alloc_data,
  input  logic [rob_pkg::DATA_W-1:0]  alloc_imm,
  input  logic [rob_pkg::TAG_W-1:0]   lookup_tag1,
  input  logic [rob_pkg::TAG_W-1:0]   lookup_tag2,
  input  logic                        cdb_valid,
  input  logic [rob_pkg::TAG_W-1:0]   cdb_tag,
  input  logic [rob_pkg::DATA_W-1:0]  cdb_value,
  input  logic                        store_ready,
  output logic                        alloc_ready,
  output logic [rob_pkg::TAG_W-1:0]   alloc_tag,
  output logic [rob_pkg::DATA_W-1:0]  lookup_value1,
  output logic                        lookup_ready1,
  output logic [rob_pkg::DATA_W-1:0]  lookup_value2,
  output logic                        lookup_ready2,
  output logic                        commit_valid,
  output logic [rob_pkg::REG_W-1:0]   commit_rd,
  output logic [rob_pkg::DATA_W-1:0]  commit_value,
  output logic [rob_pkg::TAG_W-1:0]   commit_tag,
  output logic                        store_valid,
  output logic [rob_pkg::DATA_W-1:0]  store_addr,
  output logic [rob_pkg::DATA_W-1:0]  store_data,
  output logic                        flush_valid,
  output logic [rob_pkg::DATA_W-1:0]  flush_pc
);
  import rob_pkg::*;

  // extra msb separates full from empty
  logic [TAG_W:0] head;
  logic [TAG_W:0] tail;
  logic [TAG_W:0] count;
  logic           full;
  logic           empty;

  // entry storage
  opcode_e           op_q   [ROB_SIZE];
  logic [REG_W-1:0]  rd_q   [ROB_SIZE];
  logic [DATA_W-1:0] value_q[ROB_SIZE];
  logic [DATA_W-1:0] data_q [ROB_SIZE];
  logic [DATA_W-1:0] imm_q  [ROB_SIZE];
  logic [ROB_SIZE-1:0] done_q;

  // head decode
  logic [TAG_W-1:0] h;
  logic             head_done;
  opcode_e          head_op;
  logic             head_branch;
  logic             retire;

  // cdb tag offset from head, for the range check
  logic [TAG_W-1:0] cdb_off;

  assign count = tail - head;
  assign full  = count == ROB_SIZE;
  assign empty = count == '0;

  assign alloc_ready = !full;
  assign alloc_tag   = tail[TAG_W-1:0];

  // operand lookup for rename
  assign lookup_value1 = value_q[lookup_tag1];
  assign lookup_ready1 = done_q[lookup_tag1];
  assign lookup_value2 = value_q[lookup_tag2];
  assign lookup_ready2 = done_q[lookup_tag2];

  assign h         = head[TAG_W-1:0];
  assign head_done = !empty && done_q[h];
  assign head_op   = op_q[h];

  // arithmetic results go back to the register file
  assign commit_valid = head_done && (head_op inside {OP_LI, OP_ADD, OP_SUB, OP_AND,
                                                      OP_XOR, OP_MUL});
  assign commit_rd    = rd_q[h];
  assign commit_value = value_q[h];
  assign commit_tag   = h;

  // store waits at the head for the memory side
  assign store_valid = head_done && head_op == OP_STORE;
  assign store_addr  = value_q[h];
  assign store_data  = data_q[h];

  // predicted not taken, so only a taken branch redirects
  assign head_branch = head_done && head_op == OP_BEQ;
  assign flush_valid = head_branch && value_q[h][0];
  assign flush_pc    = imm_q[h];

  assign retire = commit_valid || (store_valid && store_ready) ||
                  (head_branch && !value_q[h][0]);

  assign cdb_off = cdb_tag - h;

  always_ff @(posedge clk_in) begin
    if (rst_in || flush_valid) begin
      head   <= '0;
      tail   <= '0;
      done_q <= '0;
    end else begin
      if (alloc_valid && !full) begin
        done_q[alloc_tag] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (cdb_valid) begin
        done_q[cdb_tag] <= 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
    end
  end

  // payload fields carry no reset
  always_ff @(posedge clk_in) begin
    if (alloc_valid && !full) begin
      op_q[alloc_tag]   <= alloc_op;
      rd_q[alloc_tag]   <= alloc_rd;
      data_q[alloc_tag] <= alloc_data;
      imm_q[alloc_tag]  <= alloc_imm;
    end
    if (cdb_valid) begin
      value_q[cdb_tag] <= cdb_value;
    end
  end

  // rename must never push into a full buffer
  a_no_alloc_full: assert property (@(posedge clk_in) disable iff (rst_in)
    alloc_valid |-> !full);

  // results only land on live entries
  a_cdb_in_range: assert property (@(posedge clk_in) disable iff (rst_in)
    cdb_valid |-> ({1'b0, cdb_off} < count));

endmodule

// File: rob_pkg.sv
package rob_pkg;

  // instruction opcodes seen by the back end
  typedef enum logic [3:0] {
    // rd = imm
    OP_LI    = 4'd0,
    // rd = rs1 op rs2
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_XOR   = 4'd4,
    // rd = low word of rs1 * rs2
    OP_MUL   = 4'd5,
    // taken when rs1 == rs2, target in imm
    OP_BEQ   = 4'd6,
    // mem[rs1 + imm] = rs2
    OP_STORE = 4'd7
  } opcode_e;

  // reorder buffer depth and tag width
  localparam int ROB_SIZE = 8;
  localparam int TAG_W = 3;

  // architectural register file
  localparam int NUM_REGS = 16;
  localparam int REG_W = 4;

  // data, address and pc width
  localparam int DATA_W = 32;

  // multiplier latency in cycles
  localparam int MUL_STAGES = 3;

endpackage

// File: src.f
rob_pkg.sv
rename_stage.sv
exec_stage.sv
cdb_arbiter.sv
reorder_buffer.sv
ooo_core_top.sv
tb_ooo_core.sv

// File: tb_ooo_core.sv
`timescale 1ns/100ps

module tb_ooo_core;
  import rob_pkg::*;

  typedef enum int {EV_COMMIT, EV_STORE, EV_FLUSH} event_e;

  logic              clk_in;
  logic              rst_in;
  logic              instr_valid;
  opcode_e           instr_op;
  logic [REG_W-1:0]  instr_rd;
  logic [REG_W-1:0]  instr_rs1;
  logic [REG_W-1:0]  instr_rs2;
  logic [DATA_W-1:0] instr_imm;
  logic              store_ready;
  logic              instr_ready;
  logic              commit_valid;
  logic [REG_W-1:0]  commit_rd;
  logic [DATA_W-1:0] commit_value;
  logic              store_valid;
  logic [DATA_W-1:0] store_addr;
  logic [DATA_W-1:0] store_data;
  logic              flush_valid;
  logic [DATA_W-1:0] flush_pc;

  // reference register file and expected event stream
  logic [DATA_W-1:0] regs [NUM_REGS];
  event_e            exp_kind [$];
  logic [DATA_W-1:0] exp_a [$];
  logic [DATA_W-1:0] exp_b [$];

  // set between a taken branch and its flush
  logic squashing = 1'b0;
  logic store_hold = 1'b0;
  logic random_ready = 1'b0;
  int   sent = 0;
  int   cycles = 0;
  int   seed = 32'h0b0b_5f83;
  int   ready_seed;

  ooo_core_top DUT (.*);

  initial clk_in = 1'b0;
  always #50 clk_in = ~clk_in;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_commit(input logic [REG_W-1:0] exp_rd, input logic [DATA_W-1:0] exp_value);
    if (commit_rd !== exp_rd)
      stop_run($sformatf("FAIL commit_rd: expected 0x%h, got 0x%h", exp_rd, commit_rd));
    if (commit_value !== exp_value)
      stop_run($sformatf("FAIL commit_value: expected 0x%h, got 0x%h", exp_value, commit_value));
  endtask

  task automatic check_store(input logic [DATA_W-1:0] exp_addr, input logic [DATA_W-1:0] exp_data);
    if (store_addr !== exp_addr)
      stop_run($sformatf("FAIL store_addr: expected 0x%h, got 0x%h", exp_addr, store_addr));
    if (store_data !== exp_data)
      stop_run($sformatf("FAIL store_data: expected 0x%h, got 0x%h", exp_data, store_data));
  endtask

  task automatic check_flush(input logic [DATA_W-1:0] exp_pc);
    if (flush_pc !== exp_pc)
      stop_run($sformatf("FAIL flush_pc: expected 0x%h, got 0x%h", exp_pc, flush_pc));
  endtask

  task automatic push_event(input event_e kind, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
    exp_kind.push_back(kind);
    exp_a.push_back(a);
    exp_b.push_back(b);
  endtask

  // oldest expected event must be of the kind the DUT just raised
  task automatic peek_event(input event_e kind, input string label,
                            output logic [DATA_W-1:0] a, output logic [DATA_W-1:0] b);
    if (exp_kind.size() == 0)
      stop_run($sformatf("the DUT raised a %s while no event was expected", label));
    if (exp_kind[0] != kind)
      stop_run($sformatf("the DUT raised a %s while a different event was due first", label));
    a = exp_a[0];
    b = exp_b[0];
  endtask

  task automatic pop_event;
    void'(exp_kind.pop_front());
    void'(exp_a.pop_front());
    void'(exp_b.pop_front());
  endtask

  // program-order model, nothing recorded under a taken branch
  task automatic predict(input opcode_e op, input logic [REG_W-1:0] rd,
                         input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2,
                         input logic [DATA_W-1:0] imm);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] res;
    a = regs[rs1];
    b = regs[rs2];
    if (!squashing) begin
      case (op)
        OP_LI:  res = imm;
        OP_ADD: res = a + b;
        OP_SUB: res = a - b;
        OP_AND: res = a & b;
        OP_XOR: res = a ^ b;
        OP_MUL: res = a * b;
        default: res = '0;
      endcase
      if (op == OP_STORE) begin
        push_event(EV_STORE, a + imm, b);
      end else if (op == OP_BEQ) begin
        if (a == b) begin
          push_event(EV_FLUSH, imm, '0);
          squashing = 1'b1;
        end
      end else begin
        push_event(EV_COMMIT, {{(DATA_W-REG_W){1'b0}}, rd}, res);
        // r0 never changes
        if (rd != '0) regs[rd] = res;
      end
    end
  endtask

  task automatic present_instr(input opcode_e op, input logic [REG_W-1:0] rd,
                               input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2,
                               input logic [DATA_W-1:0] imm);
    @(negedge clk_in);
    instr_valid = 1'b1;
    instr_op    = op;
    instr_rd    = rd;
    instr_rs1   = rs1;
    instr_rs2   = rs2;
    instr_imm   = imm;
    sent++;
  endtask

  // valid stays high afterwards until the next present or drain
  task automatic wait_accept;
    do @(posedge clk_in); while (!instr_ready);
    predict(instr_op, instr_rd, instr_rs1, instr_rs2, instr_imm);
  endtask

  task automatic send_instr(input opcode_e op, input logic [REG_W-1:0] rd,
                            input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2,
                            input logic [DATA_W-1:0] imm);
    present_instr(op, rd, rs1, rs2, imm);
    wait_accept();
  endtask

  task automatic drain;
    @(negedge clk_in);
    instr_valid = 1'b0;
    while (exp_kind.size() != 0) @(posedge clk_in);
    repeat (3) @(posedge clk_in);
  endtask

  // one event per cycle at most, all from the head entry
  always @(posedge clk_in) begin : event_monitor
    logic [DATA_W-1:0] ea;
    logic [DATA_W-1:0] eb;
    if (!rst_in) begin
      if (store_hold && !store_valid)
        stop_run("store_valid fell before the store was accepted");
      store_hold = store_valid && !store_ready;
      if (commit_valid) begin
        peek_event(EV_COMMIT, "commit", ea, eb);
        check_commit(ea[REG_W-1:0], eb);
        pop_event();
      end
      // compared every cycle, so a stalled store must hold steady
      if (store_valid) begin
        peek_event(EV_STORE, "store", ea, eb);
        check_store(ea, eb);
        if (store_ready) pop_event();
      end
      if (flush_valid) begin
        peek_event(EV_FLUSH, "flush", ea, eb);
        check_flush(ea);
        pop_event();
        squashing = 1'b0;
      end
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > 40 * sent + 200)
      stop_run($sformatf("timeout after %0d cycles with %0d instructions sent", cycles, sent));
  end

  // random memory back-pressure for the mixed run
  always @(negedge clk_in) begin
    if (random_ready) store_ready = ($random(ready_seed) & 3) != 0;
  end

  task automatic test_alu_chain;
    send_instr(OP_LI, 4'd1, 4'd0, 4'd0, 32'h0000_1234);
    send_instr(OP_LI, 4'd2, 4'd0, 4'd0, 32'h0f0f_0f0f);
    send_instr(OP_ADD, 4'd3, 4'd1, 4'd2, '0);
    send_instr(OP_SUB, 4'd4, 4'd3, 4'd1, '0);
    send_instr(OP_AND, 4'd5, 4'd4, 4'd3, '0);
    send_instr(OP_XOR, 4'd6, 4'd5, 4'd2, '0);
    // r0 write is dropped, the read below still sees zero
    send_instr(OP_LI, 4'd0, 4'd0, 4'd0, 32'hdead_beef);
    send_instr(OP_ADD, 4'd7, 4'd0, 4'd1, '0);
    drain();
  endtask

  task automatic test_mul_order;
    send_instr(OP_LI, 4'd1, 4'd0, 4'd0, 32'h0001_0003);
    send_instr(OP_LI, 4'd2, 4'd0, 4'd0, 32'h0002_0005);
    send_instr(OP_MUL, 4'd3, 4'd1, 4'd2, '0);
    // independent alu work finishes before the product
    send_instr(OP_ADD, 4'd4, 4'd1, 4'd1, '0);
    send_instr(OP_XOR, 4'd5, 4'd1, 4'd2, '0);
    send_instr(OP_AND, 4'd6, 4'd2, 4'd1, '0);
    send_instr(OP_SUB, 4'd7, 4'd3, 4'd1, '0);
    drain();
  endtask

  task automatic test_store_backpressure;
    send_instr(OP_LI, 4'd8, 4'd0, 4'd0, 32'h0000_1000);
    send_instr(OP_LI, 4'd9, 4'd0, 4'd0, 32'hcafe_f00d);
    send_instr(OP_STORE, 4'd0, 4'd8, 4'd9, 32'h0000_0010);
    drain();
    @(negedge clk_in);
    store_ready = 1'b0;
    send_instr(OP_STORE, 4'd0, 4'd8, 4'd9, 32'h0000_0040);
    for (int i = 0; i < ROB_SIZE - 1; i++) begin
      send_instr(OP_LI, 4'(i + 1), 4'd0, 4'd0, 32'h100 + i);
    end
    // buffer full behind the stalled store
    present_instr(OP_ADD, 4'd10, 4'd1, 4'd2, '0);
    repeat (6) begin
      @(posedge clk_in);
      if (instr_ready) stop_run("instr_ready rose while the reorder buffer was full");
    end
    @(negedge clk_in);
    store_ready = 1'b1;
    wait_accept();
    drain();
  endtask

  task automatic test_branch_flush;
    send_instr(OP_LI, 4'd1, 4'd0, 4'd0, 32'd5);
    send_instr(OP_LI, 4'd2, 4'd0, 4'd0, 32'd7);
    send_instr(OP_BEQ, 4'd0, 4'd1, 4'd2, 32'h0000_0100);
    send_instr(OP_ADD, 4'd3, 4'd1, 4'd2, '0);
    send_instr(OP_BEQ, 4'd0, 4'd1, 4'd1, 32'h0000_0200);
    // younger work that the flush squashes
    send_instr(OP_LI, 4'd4, 4'd0, 4'd0, 32'h0000_0055);
    send_instr(OP_ADD, 4'd5, 4'd1, 4'd2, '0);
    drain();
    send_instr(OP_ADD, 4'd6, 4'd4, 4'd3, '0);
    send_instr(OP_XOR, 4'd7, 4'd5, 4'd1, '0);
    drain();
  endtask

  task automatic test_random_mix;
    logic [31:0]       r;
    logic [DATA_W-1:0] imm;
    random_ready = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r   = $random(seed);
      imm = $random(seed);
      send_instr(opcode_e'({1'b0, r[2:0]}), r[7:4], r[11:8], r[15:12], imm);
    end
    drain();
    @(negedge clk_in);
    random_ready = 1'b0;
    store_ready  = 1'b1;
  endtask

  initial begin
    rst_in      = 1'b1;
    instr_valid = 1'b0;
    instr_op    = OP_LI;
    instr_rd    = '0;
    instr_rs1   = '0;
    instr_rs2   = '0;
    instr_imm   = '0;
    store_ready = 1'b1;
    ready_seed  = seed + 1;
    for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    repeat (4) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    test_alu_chain();
    test_mul_order();
    test_store_backpressure();
    test_branch_flush();
    test_random_mix();
    repeat (10) @(posedge clk_in);
    if (exp_kind.size() != 0) begin
      stop_run($sformatf("%0d expected events never appeared", exp_kind.size()));
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
